// File: verilog/obi_pkg.sv
// --------------------------------------------------
// OBI harness package
// Bus widths, command and FSM encodings, and the
// request and response bundles for both OBI ports
// --------------------------------------------------

package obi_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    localparam int unsigned ADDR_WIDTH     = 32;
    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned BE_WIDTH       = 4;
    // Word index into the shared memory, 1024 words
    localparam int unsigned RAM_ADDR_WIDTH = 10;

    // Command opcodes seen by the master
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FETCH = 2'd2
    } mem_op_e;

    // Master transaction FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_RSP  = 2'd2,
        ST_DONE = 2'd3
    } mst_state_e;

    // --------------------------------------------------
    // Bundles
    // --------------------------------------------------
    // One command from the outside world
    typedef struct packed {
        mem_op_e                 op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [BE_WIDTH-1:0]     be;
    } mem_cmd_t;

    // Address phase plus side-band, master to memory
    typedef struct packed {
        logic                    req;
        logic                    reqpar;
        logic                    we;
        logic [BE_WIDTH-1:0]     be;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic                    rready;
    } obi_req_t;

    // Grant and response phase, memory to master
    typedef struct packed {
        logic                    gnt;
        logic                    rvalid;
        logic [DATA_WIDTH-1:0]   rdata;
        logic                    err;
    } obi_rsp_t;

endpackage

// File: verilog/obi_master.sv
// --------------------------------------------------
// OBI command master
// Turns one strobed command into a single OBI transfer
// on the instruction or data port, core style
// --------------------------------------------------
`timescale 1ns/10ps

module obi_master (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  obi_pkg::mem_cmd_t   cmd_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [31:0]         rdata_o,
    output logic                err_o,
    output obi_pkg::obi_req_t   instr_req_o,
    input  obi_pkg::obi_rsp_t   instr_rsp_i,
    output obi_pkg::obi_req_t   data_req_o,
    input  obi_pkg::obi_rsp_t   data_rsp_i
);
    import obi_pkg::*;

    mst_state_e             state_q;
    mst_state_e             state_d;
    // Latched command, held for the whole transaction
    mem_cmd_t               cmd_q;
    logic                   is_fetch;
    logic                   req_active;
    // Response of whichever port carries the command
    obi_rsp_t               sel_rsp;
    logic [DATA_WIDTH-1:0]  rdata_q;
    logic                   err_q;

    assign is_fetch   = (cmd_q.op == OP_FETCH);
    assign req_active = (state_q == ST_REQ);
    assign sel_rsp    = is_fetch ? instr_rsp_i : data_rsp_i;

    // --------------------------------------------------
    // Transaction FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Strobes only count while idle
                if (cmd_valid_i) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                // Address phase ends on the grant cycle
                if (sel_rsp.gnt) begin
                    state_d = ST_RSP;
                end
            end
            ST_RSP: begin
                if (sel_rsp.rvalid) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command and result registers
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
        // Capture the response phase once it arrives
        if (state_q == ST_RSP && sel_rsp.rvalid) begin
            rdata_q <= sel_rsp.rdata;
            err_q   <= sel_rsp.err;
        end
    end

    // --------------------------------------------------
    // Instruction port
    // --------------------------------------------------
    always_comb begin
        instr_req_o.req    = req_active & is_fetch;
        // Request parity is the inverted req
        instr_req_o.reqpar = ~(req_active & is_fetch);
        // Fetches are full-word reads only
        instr_req_o.we     = 1'b0;
        instr_req_o.be     = '1;
        instr_req_o.addr   = {cmd_q.addr[ADDR_WIDTH-1:2], 2'b00};
        instr_req_o.wdata  = '0;
        instr_req_o.rready = 1'b1;
    end

    // --------------------------------------------------
    // Data port
    // --------------------------------------------------
    always_comb begin
        data_req_o.req    = req_active & ~is_fetch;
        data_req_o.reqpar = ~(req_active & ~is_fetch);
        data_req_o.we     = (cmd_q.op == OP_WRITE);
        data_req_o.be     = cmd_q.be;
        data_req_o.addr   = cmd_q.addr;
        data_req_o.wdata  = cmd_q.wdata;
        // No back-pressure on the response phase
        data_req_o.rready = 1'b1;
    end

    // Status towards the command side
    assign busy_o  = (state_q != ST_IDLE);
    assign done_o  = (state_q == ST_DONE);
    assign rdata_o = rdata_q;
    assign err_o   = err_q;

endmodule

// File: verilog/obi_sram.sv
// --------------------------------------------------
// Dual-port OBI memory
// Shared 1024-word array with stall-driven grant wait
// states, byte-enable writes and range errors
// --------------------------------------------------
`timescale 1ns/10ps

module obi_sram (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  obi_pkg::obi_req_t   instr_req_i,
    output obi_pkg::obi_rsp_t   instr_rsp_o,
    input  obi_pkg::obi_req_t   data_req_i,
    output obi_pkg::obi_rsp_t   data_rsp_o
);
    import obi_pkg::*;

    // Storage, shared by both ports
    logic [DATA_WIDTH-1:0]      mem_q [2**RAM_ADDR_WIDTH];

    // Port 0 is instruction, port 1 is data
    obi_req_t                   port_req [2];
    logic [1:0]                 port_gnt;
    logic [1:0]                 port_in_range;
    logic [RAM_ADDR_WIDTH-1:0]  port_idx [2];

    // Response phase registers
    logic [1:0]                 rvalid_q;
    logic [1:0]                 err_q;
    logic [DATA_WIDTH-1:0]      rdata_q [2];

    assign port_req[0] = instr_req_i;
    assign port_req[1] = data_req_i;

    // --------------------------------------------------
    // Address phase decode
    // --------------------------------------------------
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            // Grant wait states come only from stall_i
            port_gnt[p]      = port_req[p].req & ~stall_i;
            port_idx[p]      = port_req[p].addr[RAM_ADDR_WIDTH+1:2];
            // Anything at 4096 or above has upper bits set
            port_in_range[p] = (port_req[p].addr[ADDR_WIDTH-1:RAM_ADDR_WIDTH+2] == '0);
        end
    end

    // --------------------------------------------------
    // Array access and response data
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < 2; p++) begin
            if (port_gnt[p]) begin
                err_q[p] <= ~port_in_range[p];
                // Out of range reads return zero
                if (port_in_range[p]) begin
                    rdata_q[p] <= mem_q[port_idx[p]];
                end else begin
                    rdata_q[p] <= '0;
                end
                // Byte-lane write, dropped when out of range
                if (port_req[p].we && port_in_range[p]) begin
                    for (int b = 0; b < BE_WIDTH; b++) begin
                        if (port_req[p].be[b]) begin
                            mem_q[port_idx[p]][b*8 +: 8] <= port_req[p].wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    // rvalid trails the grant by one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= '0;
        end else begin
            rvalid_q <= port_gnt;
        end
    end

    // --------------------------------------------------
    // Response bundles
    // --------------------------------------------------
    always_comb begin
        instr_rsp_o.gnt    = port_gnt[0];
        instr_rsp_o.rvalid = rvalid_q[0];
        instr_rsp_o.rdata  = rdata_q[0];
        instr_rsp_o.err    = err_q[0];

        data_rsp_o.gnt     = port_gnt[1];
        data_rsp_o.rvalid  = rvalid_q[1];
        data_rsp_o.rdata   = rdata_q[1];
        data_rsp_o.err     = err_q[1];
    end

endmodule

// File: verilog/obi_subsys.sv
// --------------------------------------------------
// OBI harness top level
// Command master on both OBI ports of one shared SRAM
// --------------------------------------------------
`timescale 1ns/10ps

module obi_subsys (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                cmd_valid_i,
    input  obi_pkg::mem_cmd_t   cmd_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [31:0]         rdata_o,
    output logic                err_o
);
    import obi_pkg::*;

    // Instruction fetch port
    obi_req_t   instr_req;
    obi_rsp_t   instr_rsp;

    // Load/store port
    obi_req_t   data_req;
    obi_rsp_t   data_rsp;

    // --------------------------------------------------
    // Core stand-in
    // --------------------------------------------------
    obi_master i_master (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .cmd_valid_i ( cmd_valid_i ),
        .cmd_i       ( cmd_i       ),
        .busy_o      ( busy_o      ),
        .done_o      ( done_o      ),
        .rdata_o     ( rdata_o     ),
        .err_o       ( err_o       ),
        .instr_req_o ( instr_req   ),
        .instr_rsp_i ( instr_rsp   ),
        .data_req_o  ( data_req    ),
        .data_rsp_i  ( data_rsp    )
    );

    // Shared memory, stall applies to both ports
    obi_sram i_sram (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .stall_i     ( stall_i     ),
        .instr_req_i ( instr_req   ),
        .instr_rsp_o ( instr_rsp   ),
        .data_req_i  ( data_req    ),
        .data_rsp_o  ( data_rsp    )
    );

endmodule

// File: tests/obi_subsys_checker.sv
// --------------------------------------------------
// OBI protocol checker
// Bound into the harness top level to watch both ports
// --------------------------------------------------
`timescale 1ns/10ps

module obi_subsys_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  obi_pkg::obi_req_t    instr_req_i,
    input  obi_pkg::obi_rsp_t    instr_rsp_i,
    input  obi_pkg::obi_req_t    data_req_i,
    input  obi_pkg::obi_rsp_t    data_rsp_i,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  obi_pkg::mst_state_e  state_i
);
    import obi_pkg::*;

    // Response one cycle after every transfer
    property rvalid_after_gnt(logic req, logic gnt, logic rvalid);
        @(posedge clk_i) disable iff (rst_i) (req && gnt) |=> rvalid;
    endproperty

    // Address phase frozen until granted
    property hold_until_gnt(obi_req_t req, logic gnt);
        @(posedge clk_i) disable iff (rst_i) (req.req && !gnt) |=> $stable(req);
    endproperty

    a_reqpar: assert property (@(posedge clk_i) disable iff (rst_i)
        (instr_req_i.reqpar == ~instr_req_i.req) && (data_req_i.reqpar == ~data_req_i.req))
        else $error("reqpar is not the inverse of req");

    a_instr_rvalid: assert property (rvalid_after_gnt(instr_req_i.req, instr_rsp_i.gnt,
                                                      instr_rsp_i.rvalid))
        else $error("instruction port rvalid missing after grant");
    a_data_rvalid: assert property (rvalid_after_gnt(data_req_i.req, data_rsp_i.gnt,
                                                     data_rsp_i.rvalid))
        else $error("data port rvalid missing after grant");

    a_instr_hold: assert property (hold_until_gnt(instr_req_i, instr_rsp_i.gnt))
        else $error("instruction request changed before grant");
    a_data_hold: assert property (hold_until_gnt(data_req_i, data_rsp_i.gnt))
        else $error("data request changed before grant");

    a_instr_no_we: assert property (@(posedge clk_i) disable iff (rst_i) !instr_req_i.we)
        else $error("write enable seen on the instruction port");

    a_done_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> busy_i)
        else $error("done without busy");

    // Memory responses only land while the master waits for them
    a_rvalid_in_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
        (instr_rsp_i.rvalid || data_rsp_i.rvalid) |-> (state_i == ST_RSP))
        else $error("rvalid while the master is not waiting in ST_RSP");

endmodule

// File: tests/tb_obi_subsys.sv
// --------------------------------------------------
// OBI harness testbench
// Replays the command file, models the shared memory
// and checks data, errors, latency and done pulses
// --------------------------------------------------
`timescale 1ns/10ps

module tb_obi_subsys;
    import obi_pkg::*;

    logic           clk_i;
    logic           rst_i;
    logic           stall_i;
    logic           cmd_valid_i;
    mem_cmd_t       cmd_i;
    logic           busy_o;
    logic           done_o;
    logic [31:0]    rdata_o;
    logic           err_o;

    // Command stream and expected values from the data file
    mem_op_e        op_q [$];
    logic [31:0]    addr_q [$];
    logic [31:0]    wdata_q [$];
    logic [3:0]     be_q [$];
    logic           stall_q [$];
    logic           eerr_q [$];
    logic [31:0]    erdata_q [$];

    // Reference copy of the shared memory
    logic [31:0]    model_mem [1024];
    integer         seed = 32'h189b_a39c;
    logic [31:0]    rnd;
    logic           stall_en;
    int             stall_run;
    int             cycle_cnt = 0;
    int             cycle_limit = 20;
    int             done_cnt = 0;
    int             err_cnt = 0;

    obi_subsys i_dut (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .stall_i     ( stall_i     ),
        .cmd_valid_i ( cmd_valid_i ),
        .cmd_i       ( cmd_i       ),
        .busy_o      ( busy_o      ),
        .done_o      ( done_o      ),
        .rdata_o     ( rdata_o     ),
        .err_o       ( err_o       )
    );

    bind obi_subsys obi_subsys_checker i_checker (
        .clk_i       ( clk_i            ),
        .rst_i       ( rst_i            ),
        .instr_req_i ( instr_req        ),
        .instr_rsp_i ( instr_rsp        ),
        .data_req_i  ( data_req         ),
        .data_rsp_i  ( data_rsp         ),
        .busy_i      ( busy_o           ),
        .done_i      ( done_o           ),
        .state_i     ( i_master.state_q )
    );

    always #50 clk_i = ~clk_i;

    // --------------------------------------------------
    // Grant stalls of at most two cycles in a row
    // --------------------------------------------------
    always @(posedge clk_i) begin
        if (stall_en && stall_run < 2) begin
            rnd = $random(seed);
            stall_i   <= rnd[0];
            stall_run <= rnd[0] ? stall_run + 1 : 0;
        end else begin
            stall_i   <= 1'b0;
            stall_run <= 0;
        end
    end

    // Watchdog and done pulse count
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst_i && done_o) begin
            done_cnt <= done_cnt + 1;
        end
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, a command never completed", cycle_cnt);
            $display("Regression failed");
            $fatal(1, "Watchdog expired");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic load_commands();
        int             fd;
        int             n;
        string          line;
        logic [31:0]    f_op;
        logic [31:0]    f_addr;
        logic [31:0]    f_wdata;
        logic [31:0]    f_be;
        logic [31:0]    f_stall;
        logic [31:0]    f_err;
        logic [31:0]    f_rdata;
        fd = $fopen("tests/obi_subsys_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the command file tests/obi_subsys_tests.txt");
            $display("Regression failed");
            $fatal(1, "No stimulus");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // Comment lines match no field and are skipped
                if (n > 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_addr, f_wdata, f_be,
                                f_stall, f_err, f_rdata);
                    if (n == 7) begin
                        op_q.push_back(mem_op_e'(f_op[1:0]));
                        addr_q.push_back(f_addr);
                        wdata_q.push_back(f_wdata);
                        be_q.push_back(f_be[3:0]);
                        stall_q.push_back(f_stall[0]);
                        eerr_q.push_back(f_err[0]);
                        erdata_q.push_back(f_rdata);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // One command from strobe to done
    // --------------------------------------------------
    task automatic run_command(input int idx);
        string          name;
        logic [31:0]    addr;
        logic [31:0]    exp_rdata;
        logic           in_range;
        int             lat;
        logic           seen;
        addr      = addr_q[idx];
        name      = $sformatf("cmd%0d_%s", idx, op_q[idx].name());
        // Everything from byte 4096 upward is outside the memory
        in_range  = (addr[31:12] == 20'd0);
        exp_rdata = in_range ? model_mem[addr[11:2]] : 32'd0;

        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_i.op    <= op_q[idx];
        cmd_i.addr  <= addr;
        cmd_i.wdata <= wdata_q[idx];
        cmd_i.be    <= be_q[idx];
        stall_en    <= stall_q[idx];
        @(negedge clk_i);
        lat = 1;
        check_value({name, "_busy_at_strobe"}, 0, busy_o);
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;

        seen = 1'b0;
        while (!seen) begin
            @(negedge clk_i);
            lat++;
            if (done_o) begin
                seen = 1'b1;
            end else begin
                check_value({name, "_busy_in_flight"}, 1, busy_o);
            end
        end

        check_value({name, "_busy_at_done"}, 1, busy_o);
        check_value({name, "_err"}, {31'd0, ~in_range}, err_o);
        check_value({name, "_err_file"}, eerr_q[idx], err_o);
        if (op_q[idx] != OP_WRITE) begin
            check_value({name, "_rdata"}, exp_rdata, rdata_o);
            check_value({name, "_rdata_file"}, erdata_q[idx], rdata_o);
        end
        if (stall_q[idx]) begin
            check_value({name, "_latency_max7"}, 1, lat <= 7);
        end else begin
            check_value({name, "_latency"}, 4, lat);
        end

        // Byte-lane merge into the model that drops out of range writes
        if (op_q[idx] == OP_WRITE && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (be_q[idx][b]) begin
                    model_mem[addr[11:2]][b*8 +: 8] = wdata_q[idx][b*8 +: 8];
                end
            end
        end

        @(negedge clk_i);
        check_value({name, "_done_single"}, 0, done_o);
        check_value({name, "_busy_released"}, 0, busy_o);
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        stall_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        stall_en    = 1'b0;
        stall_run   = 0;
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = 32'd0;
        end
        load_commands();
        cycle_limit = 10 * op_q.size() + 20;

        // Reset for five clock edges with quiet outputs
        for (int i = 0; i < 5; i++) begin
            @(posedge clk_i);
            if (i == 4) begin
                rst_i <= 1'b0;
            end
            @(negedge clk_i);
            check_value("reset_busy", 0, busy_o);
            check_value("reset_done", 0, done_o);
        end
        repeat (2) begin
            @(negedge clk_i);
            check_value("idle_busy", 0, busy_o);
            check_value("idle_done", 0, done_o);
        end

        for (int i = 0; i < op_q.size(); i++) begin
            run_command(i);
        end
        stall_en <= 1'b0;
        @(negedge clk_i);
        check_value("done_count", op_q.size(), done_cnt);

        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/obi_subsys_tests.txt
# op addr wdata be stall exp_err exp_rdata, all hex, rdata unused on writes
# op 0 read 1 write 2 fetch, stall 1 turns on random grant stalls
1 00000010 cafef00d f 0 0 00000000
0 00000010 00000000 0 0 0 cafef00d
1 00000020 11223344 f 0 0 00000000
1 00000020 aabbccdd 5 0 0 00000000
0 00000020 00000000 0 0 0 11bb33dd
1 00000020 99999999 8 0 0 00000000
0 00000020 00000000 0 0 0 99bb33dd
1 00000024 01020304 f 0 0 00000000
1 00000024 ffffffff 6 0 0 00000000
0 00000024 00000000 0 0 0 01ffff04
2 00000010 00000000 0 0 0 cafef00d
2 00000026 00000000 0 0 0 01ffff04
2 00000023 00000000 0 0 0 99bb33dd
0 00001000 00000000 0 0 1 00000000
1 00001010 deadbeef f 0 1 00000000
0 00000010 00000000 0 0 0 cafef00d
2 00002000 00000000 0 0 1 00000000
1 00001020 12345678 f 0 1 00000000
0 00000020 00000000 0 0 0 99bb33dd
1 00000ffc 5a5aa5a5 f 0 0 00000000
0 00000ffc 00000000 0 0 0 5a5aa5a5
1 00000100 0badc0de f 1 0 00000000
0 00000100 00000000 0 1 0 0badc0de
1 00000104 76543210 f 1 0 00000000
1 00000104 aaaaaaaa 2 1 0 00000000
0 00000104 00000000 0 1 0 7654aa10
2 00000100 00000000 0 1 0 0badc0de
0 00001004 00000000 0 1 1 00000000
1 00000010 13579bdf c 1 0 00000000
2 00000012 00000000 0 1 0 1357f00d

// File: build.f
verilog/obi_pkg.sv
verilog/obi_master.sv
verilog/obi_sram.sv
verilog/obi_subsys.sv
tests/obi_subsys_checker.sv
tests/tb_obi_subsys.sv

// File: Bender.yml
package:
  name: obi_subsys

sources:
  - files:
      - verilog/obi_pkg.sv
      - verilog/obi_master.sv
      - verilog/obi_sram.sv
      - verilog/obi_subsys.sv
  - target: test
    files:
      - tests/obi_subsys_checker.sv
      - tests/tb_obi_subsys.sv
